/* frv_front.f */
verilog/frv_core_pkg.sv
verilog/frv_decode_pkg.sv
verilog/frv_pipeline_register.sv
verilog/frv_pipeline_fetch.sv
verilog/frv_pipeline_decode.sv
verilog/frv_pipeline_front.sv
dv/frv_tb_clock.sv
dv/frv_front_tb.sv

/* Makefile */
# Verilator build and run of the front end testbench

.PHONY: sim clean

sim:
	verilator --binary --assert --top-module frv_front_tb -f frv_front.f
	out=$$(./obj_dir/Vfrv_front_tb); echo "$$out"; echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir

/* dv/frv_front_tb.sv */
/*
 * Random testbench for the front end. Memory is a 256-word table indexed by
 * address bits 9:2, so addresses alias. Flush is only driven in the redirect
 * cycle, and records on o_s2 in that cycle are treated as discarded.
 */
module frv_front_tb import frv_core_pkg::*, frv_decode_pkg::*;;

    localparam pc_t RESET_PC = 32'h8000_0000;
    localparam logic [6:0] OPC_TAB [10] = '{OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_JALR,
        OPC_BRANCH, OPC_LOAD, OPC_STORE, OPC_OP_IMM, OPC_OP, OPC_SYSTEM};
    localparam logic [4:0] ALU_UOP [8] = '{UOP_ADD, UOP_SLL, UOP_SLT, UOP_SLTU,
        UOP_XOR, UOP_SRL, UOP_OR, UOP_AND};
    localparam logic [4:0] BR_UOP [8] = '{UOP_BEQ, UOP_BNE, UOP_BGEU, UOP_BGEU,
        UOP_BLT, UOP_BGE, UOP_BLTU, UOP_BGEU};

    logic g_clk, i_rst, i_cf_req, i_flush, i_imem_stall, i_imem_error, i_s2_busy;
    logic o_cf_ack, o_imem_req, o_s2_valid;
    pc_t i_cf_target, o_imem_addr;
    logic [XLEN-1:0] i_imem_rdata;
    decoded_t o_s2;

    logic [31:0] lfsr = 32'd97;       // Random state
    logic [31:0] mem [256];           // Instruction table
    logic [31:0] stall_thr, busy_thr, cf_thr; // Out of 256
    pc_t      exp_q [$];              // PCs of accepted requests
    logic     resp_due, hold_prev, have_last, target_due;
    pc_t      resp_pc, last_pc, exp_target;
    decoded_t held;
    int       errors, checks, tests_run, tests_failed, seen_err, seen_ill;

    frv_tb_clock u_clock (.o_clk(g_clk), .o_rst(i_rst));

    frv_pipeline_front #(.FRV_PC_RESET_VALUE(RESET_PC)) dut (.*);

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int k = 0; k < n; k++) begin
            b    = lfsr[0];
            lfsr = (lfsr >> 1) ^ (b ? 32'h8020_0003 : 32'h0);
            r    = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic logic addr_error(input pc_t pc);
        return pc[6:2] == 5'b10110;   // Error pattern in the index
    endfunction

    // --------------------
    // Reference decoder

    function automatic decoded_t model_decode(input pc_t pc, input logic [31:0] w,
                                              input logic err);
        decoded_t   d;
        logic [2:0] f3;
        logic [6:0] f7;
        logic       ok;
        f3 = w[14:12];
        f7 = w[31:25];
        d = '{rd: w[11:7], rs1: w[19:15], rs2: w[24:20], imm: '0, pc: pc,
              uop: UOP_ILLEGAL, fu: FU_ALU, trap: 1'b0, instr: w};
        ok = 1'b0;
        case (w[6:0])
            OPC_LUI, OPC_AUIPC: begin
                ok    = 1'b1;
                d.imm = {w[31:12], 12'h000};
                d.uop = (w[6:0] == OPC_LUI) ? UOP_LUI : UOP_AUIPC;
            end
            OPC_JAL: begin
                ok    = 1'b1;
                d.fu  = FU_JUMP;
                d.uop = UOP_JAL;
                d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            OPC_JALR: begin
                ok    = (f3 == 3'd0);
                d.fu  = FU_JUMP;
                d.uop = UOP_JALR;
                d.imm = {{20{w[31]}}, w[31:20]};
            end
            OPC_BRANCH: begin
                ok    = (f3[2:1] != 2'b01);
                d.fu  = FU_BRANCH;
                d.uop = uop_t'(BR_UOP[f3]);
                d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            end
            OPC_LOAD, OPC_STORE: begin
                ok    = (w[5] ? (f3 < 3'd3) : (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5}));
                d.fu  = FU_MEM;
                d.uop = w[5] ? UOP_STORE : UOP_LOAD;
                d.imm = w[5] ? {{20{w[31]}}, w[31:25], w[11:7]} : {{20{w[31]}}, w[31:20]};
            end
            OPC_OP_IMM: begin
                ok    = (f3 == 3'd1) ? (f7 == 7'h00) :
                        (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
                d.uop = (f3 == 3'd5 && w[30]) ? UOP_SRA : uop_t'(ALU_UOP[f3]);
                d.imm = {{20{w[31]}}, w[31:20]};
            end
            OPC_OP: begin
                ok    = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
                d.uop = uop_t'(ALU_UOP[f3]);
                if (w[30] && f3 == 3'd0) d.uop = UOP_SUB;
                if (w[30] && f3 == 3'd5) d.uop = UOP_SRA;
            end
            OPC_SYSTEM: begin
                ok    = (w == 32'h0000_0073) || (w == 32'h0010_0073);
                d.fu  = FU_SYS;
                d.uop = w[20] ? UOP_EBREAK : UOP_ECALL;
            end
            default: ok = 1'b0;
        endcase
        d.trap = err | ~ok;
        if (d.trap) begin
            d.fu  = FU_SYS;
            d.uop = err ? UOP_FETCH_ERR : UOP_ILLEGAL;
        end
        return d;
    endfunction

    // --------------------
    // Checks

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("Mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        checks++;
        assert (cond) else begin
            $display("Error: %s", what);
            errors++;
        end
    endtask

    task automatic deliver();
        decoded_t e;
        pc_t      p;
        if (exp_q.size() == 0) begin
            check_true(1'b0, "record delivered with no request outstanding");
            return;
        end
        p = exp_q.pop_front();
        e = model_decode(p, mem[p[9:2]], addr_error(p));
        check_val("o_s2.pc", o_s2.pc, e.pc);
        check_val("o_s2.instr", o_s2.instr, e.instr);
        check_val("o_s2.imm", o_s2.imm, e.imm);
        check_val("o_s2.rd", 32'(o_s2.rd), 32'(e.rd));
        check_val("o_s2.rs1", 32'(o_s2.rs1), 32'(e.rs1));
        check_val("o_s2.rs2", 32'(o_s2.rs2), 32'(e.rs2));
        check_val("o_s2.uop", 32'(o_s2.uop), 32'(e.uop));
        check_val("o_s2.fu", 32'(o_s2.fu), 32'(e.fu));
        check_val("o_s2.trap", 32'(o_s2.trap), 32'(e.trap));
        if (target_due) check_val("o_s2.pc after redirect", o_s2.pc, exp_target);
        if (have_last) check_val("o_s2.pc step", o_s2.pc, last_pc + 32'd4);
        target_due = 1'b0;
        have_last  = 1'b1;
        last_pc    = o_s2.pc;
        if (o_s2.uop == UOP_FETCH_ERR) seen_err++;
        if (o_s2.uop == UOP_ILLEGAL) seen_ill++;
    endtask

    // --------------------
    // One clock cycle, entered at a falling edge: sample, drive after the rising edge

    task automatic cycle();
        check_val("o_cf_ack", 32'(o_cf_ack), 32'(i_cf_req & ~i_imem_stall));
        if (hold_prev) begin
            check_true(o_s2_valid, "o_s2_valid dropped while held by busy");
            checks++;
            assert (o_s2 === held) else begin
                $display("Mismatch o_s2 while held: got %h expected %h", o_s2, held);
                errors++;
            end
        end
        if (o_cf_ack) begin
            exp_q.delete();           // Everything older is dropped
            target_due = 1'b1;
            exp_target = i_cf_target;
            have_last  = 1'b0;
        end else if (o_s2_valid && !i_s2_busy) begin
            deliver();
        end
        hold_prev = o_s2_valid & i_s2_busy & ~o_cf_ack;
        held      = o_s2;
        resp_due  = o_imem_req & ~i_imem_stall;
        resp_pc   = o_imem_addr;
        if (resp_due) exp_q.push_back(o_imem_addr);
        @(posedge g_clk);
        #1;
        i_imem_rdata = resp_due ? mem[resp_pc[9:2]] : 32'h0;
        i_imem_error = resp_due & addr_error(resp_pc);
        i_imem_stall = rand_bits(8) < stall_thr;
        i_s2_busy    = rand_bits(8) < busy_thr;
        i_cf_req     = rand_bits(8) < cf_thr;
        i_cf_target  = RESET_PC + (rand_bits(8) << 2);
        i_flush      = i_cf_req & ~i_imem_stall; // Only with a taken redirect
        @(negedge g_clk);
    endtask

    task automatic run_test(input string name, input int n, input logic [31:0] st,
                            input logic [31:0] bz, input logic [31:0] cf, input logic traps);
        int err0;
        int cnt;
        err0 = errors;
        {seen_err, seen_ill} = '0;
        {stall_thr, busy_thr, cf_thr} = {st, bz, cf};
        repeat (n) cycle();
        {stall_thr, busy_thr, cf_thr} = {32'd256, 32'd0, 32'd0}; // Stop issue, drain
        cnt = 0;
        while (exp_q.size() != 0 && cnt < 100) begin
            cycle();
            cnt++;
        end
        check_true(exp_q.size() == 0,
                   $sformatf("timeout, %0d accepted words never delivered in %s",
                             exp_q.size(), name));
        exp_q.delete();
        if (traps) begin
            check_true(seen_err > 0, "no fetch-error trap was delivered");
            check_true(seen_ill > 0, "no illegal-instruction trap was delivered");
        end
        tests_run++;
        if (errors != err0) tests_failed++;
        $display("Test %0d %s: %0d errors", tests_run, name, errors - err0);
    endtask

    initial begin
        int k;
        int kind;
        {i_cf_req, i_flush, i_imem_stall, i_imem_error, i_s2_busy} = '0;
        {i_cf_target, i_imem_rdata} = '0;
        {stall_thr, busy_thr, cf_thr} = '0;
        {resp_due, hold_prev, have_last, target_due} = '0;
        {errors, checks, tests_run, tests_failed, seen_err, seen_ill} = '0;
        for (int i = 0; i < 256; i++) begin
            kind   = int'(rand_bits(4));
            mem[i] = rand_bits(32);             // Random word, mostly illegal
            if (kind < 10) begin
                mem[i][6:0] = OPC_TAB[kind];
                if (kind >= 7) mem[i][31:25] = rand_bits(1) ? 7'h20 : 7'h00;
                if (kind == 9) mem[i] = rand_bits(1) ? 32'h0010_0073 : 32'h0000_0073;
            end
        end
        k = 0;
        @(negedge g_clk);
        while (i_rst && k < 20) begin
            @(negedge g_clk);
            k++;
        end
        if (i_rst) begin
            $display("Timeout: reset never released");
            $display("Some tests failed");
            $finish;
        end else begin
            // ---------------------
            // Reset state, first cycle out of reset
            check_val("o_s2_valid", 32'(o_s2_valid), 32'd0);
            check_val("o_imem_req", 32'(o_imem_req), 32'd1);
            check_val("o_imem_addr", o_imem_addr, RESET_PC);
            tests_run++;
            if (errors != 0) tests_failed++;
            $display("Test 1 reset state: %0d errors", errors);
            run_test("sequential decode", 600, 0, 0, 0, 1'b0);
            run_test("stall and busy", 1500, 80, 100, 0, 1'b0);
            run_test("redirect and flush", 1500, 60, 60, 20, 1'b0);
            run_test("fetch error and illegal", 800, 0, 0, 8, 1'b1);
            $display("Tests run %0d, failed %0d, checks %0d, errors %0d",
                     tests_run, tests_failed, checks, errors);
            if (errors == 0) begin
                $display("All tests passed");
            end else begin
                $display("Some tests failed");
            end
            $finish;
        end
    end

endmodule

/* dv/frv_tb_clock.sv */
/*
 * Clock with period 8 and a reset held high for the first 5 rising edges.
 */
module frv_tb_clock (
    output logic o_clk, // Testbench clock
    output logic o_rst  // Sync reset, active high
);

    initial begin
        o_clk = 1'b0;
        o_rst = 1'b1;
        repeat (5) @(posedge o_clk);
        #1 o_rst = 1'b0;            // Released just after the 5th edge
    end

    always #4 o_clk = ~o_clk;

endmodule

/* verilog/frv_pipeline_front.sv */
/*
 * Front end top. Fetch feeds the fetch register, decode sits between
 * the fetch and decode registers. Flush must come with a redirect.
 */
module frv_pipeline_front import frv_core_pkg::*, frv_decode_pkg::*; #(
    parameter pc_t FRV_PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic            g_clk,        // Core clock
    input  logic            i_rst,        // Sync reset
    input  logic            i_cf_req,     // Control flow change request
    input  pc_t             i_cf_target,  // Redirect destination
    input  logic            i_flush,      // Empty both stages
    input  logic            i_imem_stall, // Memory stall
    input  logic [XLEN-1:0] i_imem_rdata, // Memory read data
    input  logic            i_imem_error, // Memory fetch error
    input  logic            i_s2_busy,    // Execute side busy
    output logic            o_cf_ack,     // Redirect taken
    output logic            o_imem_req,   // Memory request
    output pc_t             o_imem_addr,  // Memory address
    output logic            o_s2_valid,   // Decoded record valid
    output decoded_t        o_s2          // Decoded record
);

    logic        f_valid;  // Fetch to first register
    fetch_word_t f_data;
    logic        s1_busy;  // First register stalls fetch
    logic        s1_valid;
    fetch_word_t s1_data;
    decoded_t    d_data;   // Decoder output
    logic        s2_busy;  // Second register stalls first

    // --------------------
    // Fetch stage

    frv_pipeline_fetch #(
        .FRV_PC_RESET_VALUE(FRV_PC_RESET_VALUE)
    ) u_fetch (
        .g_clk        (g_clk),
        .i_rst        (i_rst),
        .i_cf_req     (i_cf_req),
        .i_cf_target  (i_cf_target),
        .i_flush      (i_flush),
        .i_imem_stall (i_imem_stall),
        .i_imem_rdata (i_imem_rdata),
        .i_imem_error (i_imem_error),
        .i_busy       (s1_busy),
        .o_cf_ack     (o_cf_ack),
        .o_imem_req   (o_imem_req),
        .o_imem_addr  (o_imem_addr),
        .o_valid      (f_valid),
        .o_data       (f_data)
    );

    frv_pipeline_register #(.PAYLOAD_T(fetch_word_t)) u_fetch_reg (
        .g_clk   (g_clk),
        .i_rst   (i_rst),
        .i_flush (i_flush),
        .i_valid (f_valid),
        .i_data  (f_data),
        .i_busy  (s2_busy),   // Chained from decode register
        .o_busy  (s1_busy),
        .o_valid (s1_valid),
        .o_data  (s1_data)
    );

    // --------------------
    // Decode stage

    frv_pipeline_decode u_decode (
        .i_word (s1_data),
        .o_dec  (d_data)
    );

    frv_pipeline_register #(.PAYLOAD_T(decoded_t)) u_decode_reg (
        .g_clk   (g_clk),
        .i_rst   (i_rst),
        .i_flush (i_flush),
        .i_valid (s1_valid),
        .i_data  (d_data),
        .i_busy  (i_s2_busy),
        .o_busy  (s2_busy),
        .o_valid (o_s2_valid),
        .o_data  (o_s2)
    );

endmodule

/* verilog/frv_pipeline_decode.sv */
/*
 * Combinational RV32I decoder. No compressed, CSR or fence support.
 * Fetch errors take priority over illegal encodings.
 * Register fields are passed raw whether or not the format uses them.
 */
module frv_pipeline_decode import frv_core_pkg::*, frv_decode_pkg::*; (
    input  fetch_word_t i_word, // Word from the first register
    output decoded_t    o_dec   // Decoded record
);

    instr_t      instr;  // Shorthand for the word
    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] imm_i, imm_s, imm_b, imm_u, imm_j;
    logic        legal;  // Encoding in the kept set

    // Shared by OP and OP-IMM, alt selects SUB/SRA
    function automatic uop_t alu_uop(input logic [2:0] f3, input logic alt);
        uop_t op;
        case (f3)
            3'b000:  op = alt ? UOP_SUB : UOP_ADD;
            3'b001:  op = UOP_SLL;
            3'b010:  op = UOP_SLT;
            3'b011:  op = UOP_SLTU;
            3'b100:  op = UOP_XOR;
            3'b101:  op = alt ? UOP_SRA : UOP_SRL;
            3'b110:  op = UOP_OR;
            default: op = UOP_AND;
        endcase
        return op;
    endfunction

    assign instr  = i_word.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // --------------------
    // Immediates

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // --------------------
    // Opcode decode

    always_comb begin
        o_dec.rd    = instr[11:7];
        o_dec.rs1   = instr[19:15];
        o_dec.rs2   = instr[24:20];
        o_dec.pc    = i_word.pc;
        o_dec.instr = instr;
        o_dec.imm   = '0;
        o_dec.uop   = UOP_ILLEGAL;
        o_dec.fu    = FU_ALU;
        legal       = 1'b0;
        case (opcode)
            OPC_LUI: begin
                legal     = 1'b1;
                o_dec.uop = UOP_LUI;
                o_dec.imm = imm_u;
            end
            OPC_AUIPC: begin
                legal     = 1'b1;
                o_dec.uop = UOP_AUIPC;
                o_dec.imm = imm_u;
            end
            OPC_JAL: begin
                legal     = 1'b1;
                o_dec.uop = UOP_JAL;
                o_dec.fu  = FU_JUMP;
                o_dec.imm = imm_j;
            end
            OPC_JALR: begin
                legal     = (funct3 == 3'b000);
                o_dec.uop = UOP_JALR;
                o_dec.fu  = FU_JUMP;
                o_dec.imm = imm_i;
            end
            OPC_BRANCH: begin
                legal     = (funct3 != 3'b010) && (funct3 != 3'b011);
                o_dec.fu  = FU_BRANCH;
                o_dec.imm = imm_b;
                case (funct3)
                    3'b000:  o_dec.uop = UOP_BEQ;
                    3'b001:  o_dec.uop = UOP_BNE;
                    3'b100:  o_dec.uop = UOP_BLT;
                    3'b101:  o_dec.uop = UOP_BGE;
                    3'b110:  o_dec.uop = UOP_BLTU;
                    default: o_dec.uop = UOP_BGEU;
                endcase
            end
            OPC_LOAD: begin
                legal = (funct3 != 3'b011) && (funct3 != 3'b110) && (funct3 != 3'b111);
                o_dec.uop = UOP_LOAD;
                o_dec.fu  = FU_MEM;
                o_dec.imm = imm_i;
            end
            OPC_STORE: begin
                legal = (funct3 == 3'b000) || (funct3 == 3'b001) || (funct3 == 3'b010);
                o_dec.uop = UOP_STORE;
                o_dec.fu  = FU_MEM;
                o_dec.imm = imm_s;
            end
            OPC_OP_IMM: begin
                if (funct3 == 3'b001) begin
                    legal = (funct7 == 7'b0000000);          // SLLI
                end else if (funct3 == 3'b101) begin
                    legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                end else begin
                    legal = 1'b1;
                end
                o_dec.uop = alu_uop(funct3, (funct3 == 3'b101) && funct7[5]); // No SUBI
                o_dec.imm = imm_i;
            end
            OPC_OP: begin
                legal = (funct7 == 7'b0000000) ||
                        ((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
                o_dec.uop = alu_uop(funct3, funct7[5]);
            end
            OPC_SYSTEM: begin
                legal    = (instr == 32'h0000_0073) || (instr == 32'h0010_0073);
                o_dec.fu = FU_SYS;
                o_dec.uop = instr[20] ? UOP_EBREAK : UOP_ECALL;
            end
            default: legal = 1'b0;                           // Includes low bits != 11
        endcase
        o_dec.trap = i_word.error | ~legal;
        if (i_word.error) begin
            o_dec.uop = UOP_FETCH_ERR;                       // Error wins
            o_dec.fu  = FU_SYS;
        end else if (!legal) begin
            o_dec.uop = UOP_ILLEGAL;
            o_dec.fu  = FU_SYS;
        end
    end

endmodule

/* verilog/frv_pipeline_fetch.sv */
/*
 * Fetch stage. One outstanding request, responses one cycle after accept.
 * A one-entry skid buffer catches a response when the next stage is busy.
 * Redirect wins over sequential fetch and drops any response in flight.
 */
module frv_pipeline_fetch import frv_core_pkg::*; #(
    parameter pc_t FRV_PC_RESET_VALUE = 32'h8000_0000
) (
    input  logic            g_clk,        // Core clock
    input  logic            i_rst,        // Sync reset
    input  logic            i_cf_req,     // Control flow change request
    input  pc_t             i_cf_target,  // Redirect destination
    input  logic            i_flush,      // Drop in-flight words
    input  logic            i_imem_stall, // Memory not accepting
    input  logic [XLEN-1:0] i_imem_rdata, // Response data
    input  logic            i_imem_error, // Response error
    input  logic            i_busy,       // First register busy
    output logic            o_cf_ack,     // Redirect taken
    output logic            o_imem_req,   // Request valid
    output pc_t             o_imem_addr,  // Request address
    output logic            o_valid,      // Word for first register
    output fetch_word_t     o_data        // PC, word and error
);

    pc_t         pc_q;         // Next sequential fetch address
    logic        pend_q;       // Response due this cycle
    pc_t         pend_pc_q;    // Address of that response
    logic        skid_valid_q; // Skid holds a word
    fetch_word_t skid_q;       // Skid contents
    fetch_word_t resp_word;    // Response paired with its PC
    logic        accept;       // Request accepted this cycle
    logic        drop;         // Discard response and skid
    logic        room;         // Space ahead for one more word
    logic        to_skid;      // Response parks in skid

    // --------------------
    // Request side

    assign o_cf_ack    = i_cf_req & ~i_imem_stall;           // Redirect only when accepted
    assign room        = ~skid_valid_q & ~(pend_q & i_busy);
    assign o_imem_req  = i_cf_req | room;                     // Redirect ignores room
    assign o_imem_addr = i_cf_req ? i_cf_target : pc_q;
    assign accept      = o_imem_req & ~i_imem_stall;
    assign drop        = o_cf_ack | i_flush;

    // --------------------
    // Response side

    always_comb begin
        resp_word.pc    = pend_pc_q;
        resp_word.instr = i_imem_rdata;
        resp_word.error = i_imem_error;
    end

    // Skid drains first so order is kept
    assign o_valid = (skid_valid_q | pend_q) & ~drop;
    assign o_data  = skid_valid_q ? skid_q : resp_word;
    assign to_skid = pend_q & ~drop & (skid_valid_q | i_busy);

    always_ff @(posedge g_clk) begin
        if (i_rst) begin
            pc_q         <= FRV_PC_RESET_VALUE;
            pend_q       <= 1'b0;
            skid_valid_q <= 1'b0;
        end else begin
            if (o_cf_ack) begin
                pc_q <= i_cf_target + pc_t'(INSTR_BYTES); // Target already requested
            end else if (accept) begin
                pc_q <= pc_q + pc_t'(INSTR_BYTES);
            end
            pend_q <= accept;
            if (drop) begin
                skid_valid_q <= 1'b0;
            end else if (to_skid) begin
                skid_valid_q <= 1'b1;
            end else if (!i_busy) begin
                skid_valid_q <= 1'b0;                     // Drained into register
            end
        end
    end

    always_ff @(posedge g_clk) begin
        if (accept) begin
            pend_pc_q <= o_imem_addr;
        end
        if (to_skid) begin
            skid_q <= resp_word;
        end
    end

endmodule

/* verilog/frv_pipeline_register.sv */
/*
 * One pipeline stage register with valid/busy handshake.
 * Holds while its own output is valid and downstream is busy.
 * Flush clears the valid bit only; payload is left as is.
 */
module frv_pipeline_register #(
    parameter type PAYLOAD_T = logic [31:0]
) (
    input  logic     g_clk,   // Core clock
    input  logic     i_rst,   // Sync reset
    input  logic     i_flush, // Drop stage contents
    input  logic     i_valid, // Upstream data valid
    input  PAYLOAD_T i_data,  // Upstream payload
    input  logic     i_busy,  // Downstream cannot take data
    output logic     o_busy,  // Stall upstream
    output logic     o_valid, // Stage holds valid data
    output PAYLOAD_T o_data   // Stage payload
);

    // Only stuck when holding something nobody takes
    assign o_busy = o_valid & i_busy;

    always_ff @(posedge g_clk) begin
        if (i_rst || i_flush) begin
            o_valid <= 1'b0;       // Control state only
        end else if (!o_busy) begin
            o_valid <= i_valid;    // Take upstream valid
        end
    end

    always_ff @(posedge g_clk) begin
        if (!o_busy) begin
            o_data <= i_data;      // Payload follows valid
        end
    end

endmodule

/* verilog/frv_decode_pkg.sv */
/*
 * Opcode constants, functional units, micro-ops and the decoded record.
 * Covers the RV32I base set only; CSR access and fence are not decoded.
 */
package frv_decode_pkg;

    // --------------------
    // RV32I major opcodes

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // Functional unit that executes the micro-op
    typedef enum logic [2:0] {
        FU_ALU    = 3'd0,
        FU_MEM    = 3'd1,
        FU_JUMP   = 3'd2,
        FU_BRANCH = 3'd3,
        FU_SYS    = 3'd4
    } fu_t;

    // --------------------
    // Micro-ops

    typedef enum logic [4:0] {
        UOP_ADD       = 5'd0,  // ALU group
        UOP_SUB       = 5'd1,
        UOP_SLL       = 5'd2,
        UOP_SLT       = 5'd3,
        UOP_SLTU      = 5'd4,
        UOP_XOR       = 5'd5,
        UOP_SRL       = 5'd6,
        UOP_SRA       = 5'd7,
        UOP_OR        = 5'd8,
        UOP_AND       = 5'd9,
        UOP_LUI       = 5'd10,
        UOP_AUIPC     = 5'd11,
        UOP_JAL       = 5'd12,
        UOP_JALR      = 5'd13,
        UOP_BEQ       = 5'd14, // Branch conditions
        UOP_BNE       = 5'd15,
        UOP_BLT       = 5'd16,
        UOP_BGE       = 5'd17,
        UOP_BLTU      = 5'd18,
        UOP_BGEU      = 5'd19,
        UOP_LOAD      = 5'd20, // Width from funct3 of instr
        UOP_STORE     = 5'd21,
        UOP_ECALL     = 5'd22,
        UOP_EBREAK    = 5'd23,
        UOP_ILLEGAL   = 5'd24, // Trap causes
        UOP_FETCH_ERR = 5'd25
    } uop_t;

    // Wide record handed to the execute side
    typedef struct packed {
        logic [4:0]  rd;    // Destination register
        logic [4:0]  rs1;   // Source register 1
        logic [4:0]  rs2;   // Source register 2
        logic [31:0] imm;   // Sign-extended immediate
        logic [31:0] pc;    // Instruction address
        uop_t        uop;   // Micro-op
        fu_t         fu;    // Functional unit
        logic        trap;  // Raise a trap
        logic [31:0] instr; // Raw word
    } decoded_t;

endpackage

/* verilog/frv_core_pkg.sv */
/*
 * Core-wide widths and the fetched-word record for the RV32I front end.
 * Only 32-bit instructions are supported, so the PC always steps by 4.
 */
package frv_core_pkg;

    // --------------------
    // Widths

    localparam int unsigned XLEN        = 32;       // Data and address width
    localparam int unsigned ILEN        = 32;       // Instruction width
    localparam int unsigned INSTR_BYTES = ILEN / 8; // PC step per instruction

    // --------------------
    // Basic types

    typedef logic [XLEN-1:0] pc_t;    // Program counter
    typedef logic [ILEN-1:0] instr_t; // Raw instruction word

    // Word as returned by the instruction memory, paired with its address
    typedef struct packed {
        pc_t    pc;    // Address the word was fetched from
        instr_t instr; // Instruction word
        logic   error; // Memory flagged a fetch error
    } fetch_word_t;

endpackage
